// ==== bench/iwdg_vectors.txt ====
# op name offset(hex) data(hex) cycles(dec)
# W write, R read and compare, P pulse after cycles, Q quiet for cycles
R kr_reset      0  0000 0
R pr_reset      4  0000 0
R rlr_reset     8  0FFF 0
R st_reset      C  0000 0
R unmapped      10 0000 0
Q idle_quiet    0  0000 50
W rlr_locked    8  0123 0
R rlr_locked    8  0FFF 0
W pr_locked     4  0005 0
R pr_locked     4  0000 0
W key_access    0  5555 0
R key_readback  0  5555 0
W rlr_open      8  0123 0
R rlr_open      8  0123 0
W pr_open       4  FFFF 0
R pr_masked     4  0007 0
W key_close     0  1234 0
W rlr_closed    8  0456 0
R rlr_closed    8  0123 0
W run_access    0  5555 0
W run_rlr       8  0005 0
W run_pr0       4  0000 0
W run_reload    0  AAAA 0
W run_start     0  CCCC 0
P pulse_pr0     0  0000 24
P repeat_pr0    0  0000 24
W pr1_access    0  5555 0
W pr1_pr        4  0001 0
W pr1_reload    0  AAAA 0
P pulse_pr1     0  0000 48
P repeat_pr1    0  0000 48
W pr7_access    0  5555 0
W pr7_pr        4  0007 0
W pr7_reload    0  AAAA 0
P pulse_pr7     0  0000 1536
W ref_access    0  5555 0
W ref_pr0       4  0000 0
W ref_reload    0  AAAA 0
Q ref_quiet     0  0000 15
W ref_kick      0  AAAA 0
Q ref_quiet     0  0000 15
W ref_kick      0  AAAA 0
P ref_expire    0  0000 24
W other_key     0  0000 0
W latch_reload  0  AAAA 0
P latch_pulse   0  0000 24
P latch_repeat  0  0000 24

// ==== project.f ====
+incdir+hw
hw/iwdg_pkg.sv
hw/iwdg_ifs.sv
hw/iwdg_wb_slave.sv
hw/iwdg_key_regs.sv
hw/iwdg_downcounter.sv
hw/iwdg_top.sv
bench/tb_iwdg.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the watchdog testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_iwdg -o sim_iwdg
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_iwdg 2>&1 | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Test OK" sim.log; then
  echo "No result found in sim.log"
  exit 1
fi
exit 0

// ==== bench/tb_iwdg.sv ====
/*
 * Testbench of the watchdog top level.
 * Reads bus operations and expected values from bench/iwdg_vectors.txt,
 * drives them on the falling clock edge and checks read data and the
 * timing of the watchdog reset pulse. Run from the project root.
 */

`include "iwdg_config.svh"

module tb_iwdg;

  localparam int NAME_W    = 8 * 24;
  localparam int ACK_LIMIT = 8;

  logic        clk;
  logic        rst;
  logic [15:0] dat_m2s;
  logic [31:0] adr_m2s;
  logic        cyc_m2s;
  logic        we_m2s;
  logic        stb_m2s;
  logic [15:0] dat_s2m;
  logic        ack_s2m;
  logic        iwdg_rst;

  // One entry per vector line.
  logic [7:0]        vec_op[$];
  logic [NAME_W-1:0] vec_name[$];
  logic [31:0]       vec_ofs[$];
  logic [15:0]       vec_dat[$];
  int                vec_cnt[$];

  int value_errs;
  int other_errs;
  int cycles;
  int limit;
  // Falling edges since the last ack or the last pulse.
  int elapsed;

  iwdg_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit is armed once the vectors are loaded.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("ERROR: run did not end within %0d cycles", limit);
      other_errs = other_errs + 1;
      finish_run();
    end
  end

  task automatic finish_run();
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic check_value(input logic [NAME_W-1:0] tname, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    assert (act_v === exp_v) else begin
      $display("CHECK FAILED %0s: expected %h, actual %h", tname, exp_v, act_v);
      value_errs = value_errs + 1;
    end
  endtask

  // One classic cycle with the request held until ack.
  task automatic bus_access(input logic is_write, input logic [31:0] ofs,
                            input logic [15:0] wdata, output logic [15:0] rdata,
                            output logic acked, output int waited);
    waited  = 0;
    acked   = 1'b0;
    adr_m2s = `IWDG_BASE_ADR + ofs;
    dat_m2s = wdata;
    we_m2s  = is_write;
    cyc_m2s = 1'b1;
    stb_m2s = 1'b1;
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited = waited + 1;
      acked  = ack_s2m;
    end
    rdata   = dat_s2m;
    cyc_m2s = 1'b0;
    stb_m2s = 1'b0;
    we_m2s  = 1'b0;
  endtask

  // With pulse set, iwdg_rst is high exactly at cycle n after the reference
  // and low right after. Without it, iwdg_rst stays low for n more cycles.
  task automatic watch_reset(input logic [NAME_W-1:0] tname, input int n, input logic pulse);
    int last;
    last = pulse ? n : elapsed + n;
    while (elapsed < last) begin
      @(negedge clk);
      elapsed = elapsed + 1;
      check_value(tname, {15'b0, pulse && (elapsed == last)}, {15'b0, iwdg_rst});
    end
    if (pulse) begin
      @(negedge clk);
      check_value(tname, 16'h0000, {15'b0, iwdg_rst});
      // The pulse is the new reference.
      elapsed = 1;
    end
  endtask

  task automatic load_vectors();
    int                fd;
    int                n;
    int                total;
    logic              done;
    logic [63:0]       tok;
    logic [NAME_W-1:0] nm;
    logic [31:0]       ofs;
    logic [15:0]       dat;
    int                cnt;
    logic [8*128-1:0]  rest;
    total = 100;
    done  = 1'b0;
    fd    = $fopen("bench/iwdg_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open bench/iwdg_vectors.txt");
      other_errs = other_errs + 1;
      done = 1'b1;
    end
    while (!done) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        done = 1'b1;
      end else if (tok[7:0] == "#") begin
        void'($fgets(rest, fd));
      end else if ($fscanf(fd, "%s %h %h %d", nm, ofs, dat, cnt) != 4) begin
        $display("ERROR: unreadable vector line after %0d vectors", vec_op.size());
        other_errs = other_errs + 1;
        done = 1'b1;
      end else begin
        vec_op.push_back(tok[7:0]);
        vec_name.push_back(nm);
        vec_ofs.push_back(ofs);
        vec_dat.push_back(dat);
        vec_cnt.push_back(cnt);
        // Waits count in full and each bus access gets four cycles.
        total = total + ((tok[7:0] == "P" || tok[7:0] == "Q") ? cnt : 4);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    limit = total;
  endtask

  initial begin
    logic [15:0] rdata;
    logic        acked;
    int          waits;
    logic        back_to_back;
    rst          = 1'b1;
    dat_m2s      = '0;
    adr_m2s      = '0;
    cyc_m2s      = 1'b0;
    we_m2s       = 1'b0;
    stb_m2s      = 1'b0;
    back_to_back = 1'b0;
    load_vectors();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < vec_op.size(); i++) begin
      case (vec_op[i])
        "W", "R": begin
          bus_access(vec_op[i] == "W", vec_ofs[i], vec_dat[i], rdata, acked, waits);
          elapsed = 0;
          if (!acked) begin
            $display("ERROR: %0s got no ack within %0d cycles", vec_name[i], ACK_LIMIT);
            other_errs = other_errs + 1;
          end else begin
            // Ack comes one cycle after the request.
            // Right after another access the request waits for that ack to drop.
            check_value(vec_name[i], back_to_back ? 16'd2 : 16'd1, 16'(waits));
            if (vec_op[i] == "R") begin
              check_value(vec_name[i], vec_dat[i], rdata);
            end
          end
          back_to_back = acked;
        end
        "P": begin
          watch_reset(vec_name[i], vec_cnt[i], 1'b1);
          back_to_back = 1'b0;
        end
        "Q": begin
          watch_reset(vec_name[i], vec_cnt[i], 1'b0);
          back_to_back = 1'b0;
        end
        default: begin
          $display("ERROR: vector %0d has an unknown opcode", i);
          other_errs = other_errs + 1;
        end
      endcase
    end
    finish_run();
  end

endmodule

// ==== hw/iwdg_top.sv ====
/*
 * Top level of the independent watchdog.
 * Wishbone classic slave pins in, watchdog reset pulse out.
 */

`include "iwdg_config.svh"

module iwdg_top import iwdg_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  dat_t dat_m2s,
  input  adr_t adr_m2s,
  input  logic cyc_m2s,
  input  logic we_m2s,
  input  logic stb_m2s,
  output dat_t dat_s2m,
  output logic ack_s2m,
  output logic iwdg_rst
);

  // Slave to register bank.
  iwdg_reg_if  rif0 ();
  // Register bank to counter.
  iwdg_ctrl_if cif0 ();

  iwdg_wb_slave slave0 (
    .clk     (clk),
    .rst     (rst),
    .dat_m2s (dat_m2s),
    .adr_m2s (adr_m2s),
    .cyc_m2s (cyc_m2s),
    .we_m2s  (we_m2s),
    .stb_m2s (stb_m2s),
    .dat_s2m (dat_s2m),
    .ack_s2m (ack_s2m),
    .rif     (rif0.bus)
  );

  iwdg_key_regs regs0 (
    .clk (clk),
    .rst (rst),
    .rif (rif0.regs),
    .cif (cif0.regs)
  );

  iwdg_downcounter cnt0 (
    .clk      (clk),
    .rst      (rst),
    .cif      (cif0.counter),
    .iwdg_rst (iwdg_rst)
  );

endmodule

// ==== hw/iwdg_downcounter.sv ====
/*
 * Prescaled 12-bit down counter of the watchdog.
 * Counts once started, reloads on command and pulses iwdg_rst
 * for one cycle when a tick finds the counter at zero.
 */

`include "iwdg_config.svh"

module iwdg_downcounter import iwdg_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  iwdg_ctrl_if.counter cif,
  output logic         iwdg_rst
);

  logic       running;
  logic [7:0] pre_cnt;
  rlr_t       cnt;
  pr_t        pr_eff;
  logic [8:0] divider;
  logic [7:0] pre_last;
  logic       tick;

  // Code 7 acts as code 6.
  assign pr_eff = (cif.pr > pr_t'(`IWDG_PR_MAX)) ? pr_t'(`IWDG_PR_MAX) : cif.pr;

  // Divider is 4 << pr, 4 to 256 clocks.
  assign divider  = 9'd4 << pr_eff;
  assign pre_last = 8'(divider - 9'd1);

  // Greater-or-equal covers a smaller pr written mid-count.
  assign tick = running && (pre_cnt >= pre_last);

  // Once started, only rst stops counting.
  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
    end else if (cif.start) begin
      running <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pre_cnt  <= '0;
      cnt      <= `IWDG_RLR_RST;
      iwdg_rst <= 1'b0;
    end else begin
      iwdg_rst <= 1'b0;
      if (cif.reload) begin
        // Refresh restarts the full period.
        pre_cnt <= '0;
        cnt     <= cif.rlr;
      end else if (tick) begin
        pre_cnt <= '0;
        if (cnt == '0) begin
          // Expired: pulse and start over.
          cnt      <= cif.rlr;
          iwdg_rst <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end else if (running) begin
        pre_cnt <= pre_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== hw/iwdg_key_regs.sv ====
/*
 * Register bank of the watchdog.
 * Holds key, prescaler and reload registers, guards the latter two
 * behind the access key and turns reload/start keys into pulses.
 */

`include "iwdg_config.svh"

module iwdg_key_regs import iwdg_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  iwdg_reg_if.regs  rif,
  iwdg_ctrl_if.regs cif
);

  key_t key;
  pr_t  pr;
  rlr_t rlr;
  logic access;
  logic kr_wr;

  // Write access to PR and RLR.
  assign access = (key == key_t'(`IWDG_KEY_ACCESS));

  // Key register write in this cycle.
  assign kr_wr = rif.wr && (rif.sel == SEL_KR);

  // Command pulses, seen by the counter at the ack edge.
  assign cif.reload = kr_wr && (rif.wdata == dat_t'(`IWDG_KEY_RELOAD));
  assign cif.start  = kr_wr && (rif.wdata == dat_t'(`IWDG_KEY_START));

  assign cif.rlr = rlr;
  assign cif.pr  = pr;

  always_ff @(posedge clk) begin
    if (rst) begin
      key <= '0;
      pr  <= '0;
      rlr <= `IWDG_RLR_RST;
    end else if (rif.wr) begin
      case (rif.sel)
        SEL_KR: begin
          // Any key other than access closes the window.
          key <= key_t'(rif.wdata);
        end
        SEL_PR: begin
          if (access) begin
            pr <= rif.wdata[`IWDG_PR_W-1:0];
          end
        end
        SEL_RLR: begin
          if (access) begin
            rlr <= rif.wdata[`IWDG_RLR_W-1:0];
          end
        end
        default: begin
          // Status and unmapped writes are dropped.
        end
      endcase
    end
  end

  // Read mux.
  always_comb begin
    case (rif.sel)
      SEL_KR:  rif.rdata = dat_t'(key);
      SEL_PR:  rif.rdata = dat_t'(pr);
      SEL_RLR: rif.rdata = dat_t'(rlr);
      // Status has no flags left.
      default: rif.rdata = '0;
    endcase
  end

endmodule

// ==== hw/iwdg_wb_slave.sv ====
/*
 * Wishbone classic slave of the watchdog.
 * Decodes the address, issues one strobe per request
 * and returns a registered acknowledge with read data.
 */

`include "iwdg_config.svh"

module iwdg_wb_slave import iwdg_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  dat_t       dat_m2s,
  input  adr_t       adr_m2s,
  input  logic       cyc_m2s,
  input  logic       we_m2s,
  input  logic       stb_m2s,
  output dat_t       dat_s2m,
  output logic       ack_s2m,
  iwdg_reg_if.bus    rif
);

  logic req;

  // New request, the ack cycle never starts another one.
  assign req = cyc_m2s && stb_m2s && !ack_s2m;

  // Strobes are valid only in the request cycle.
  assign rif.wr    = req && we_m2s;
  assign rif.rd    = req && !we_m2s;
  assign rif.wdata = dat_m2s;

  // Address decode.
  always_comb begin
    if (adr_m2s == adr_t'(`IWDG_BASE_ADR + `IWDG_KR_OFS)) begin
      rif.sel = SEL_KR;
    end else if (adr_m2s == adr_t'(`IWDG_BASE_ADR + `IWDG_PR_OFS)) begin
      rif.sel = SEL_PR;
    end else if (adr_m2s == adr_t'(`IWDG_BASE_ADR + `IWDG_RLR_OFS)) begin
      rif.sel = SEL_RLR;
    end else if (adr_m2s == adr_t'(`IWDG_BASE_ADR + `IWDG_ST_OFS)) begin
      rif.sel = SEL_ST;
    end else begin
      // Unmapped, still acknowledged.
      rif.sel = SEL_NONE;
    end
  end

  // Ack one cycle after the request, for one cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_s2m <= 1'b0;
    end else begin
      ack_s2m <= req;
    end
  end

  // Read data lines up with ack.
  // Zero on writes and between accesses.
  always_ff @(posedge clk) begin
    if (rif.rd) begin
      dat_s2m <= rif.rdata;
    end else begin
      dat_s2m <= '0;
    end
  end

endmodule

// ==== hw/iwdg_ifs.sv ====
/*
 * Internal interfaces of the watchdog.
 * iwdg_reg_if links the bus slave to the register bank.
 * iwdg_ctrl_if links the register bank to the down counter.
 */

`include "iwdg_config.svh"

interface iwdg_reg_if import iwdg_pkg::*; ();

  // One-cycle write and read strobes.
  logic     wr;
  logic     rd;
  // Decoded register and write data.
  reg_sel_t sel;
  dat_t     wdata;
  // Read data, combinational from sel.
  dat_t     rdata;

  // Bus side.
  modport bus (
    output wr,
    output rd,
    output sel,
    output wdata,
    input  rdata
  );

  // Register side, reads need no strobe.
  modport regs (
    input  wr,
    input  sel,
    input  wdata,
    output rdata
  );

endinterface

interface iwdg_ctrl_if import iwdg_pkg::*; ();

  // One-cycle command pulses.
  logic reload;
  logic start;
  // Programmed levels.
  rlr_t rlr;
  pr_t  pr;

  modport regs (
    output reload,
    output start,
    output rlr,
    output pr
  );

  modport counter (
    input reload,
    input start,
    input rlr,
    input pr
  );

endinterface

// ==== hw/iwdg_pkg.sv ====
/*
 * Types shared by the watchdog modules.
 * Register fields, bus words and the register select code.
 */

`include "iwdg_config.svh"

package iwdg_pkg;

  // Key register value.
  typedef logic [`IWDG_KEY_W-1:0] key_t;

  // Prescaler code, divider is 4 << code.
  typedef logic [`IWDG_PR_W-1:0] pr_t;

  // Reload value or live count.
  typedef logic [`IWDG_RLR_W-1:0] rlr_t;

  // Bus data word.
  typedef logic [`IWDG_DAT_W-1:0] dat_t;

  // Bus address.
  typedef logic [`IWDG_ADR_W-1:0] adr_t;

  // Register addressed by the current bus cycle.
  typedef enum logic [2:0] {
    SEL_KR,
    SEL_PR,
    SEL_RLR,
    SEL_ST,
    SEL_NONE
  } reg_sel_t;

endpackage

// ==== hw/iwdg_config.svh ====
/*
 * Build-time constants of the watchdog.
 * Addresses, widths, key values and reset values.
 * Include this header wherever one of these constants is needed.
 */

`ifndef IWDG_CONFIG_SVH
`define IWDG_CONFIG_SVH

// Base address of the register block.
`define IWDG_BASE_ADR 32'h0100_0000

// Byte offsets of the registers.
`define IWDG_KR_OFS  32'h0000_0000
`define IWDG_PR_OFS  32'h0000_0004
`define IWDG_RLR_OFS 32'h0000_0008
`define IWDG_ST_OFS  32'h0000_000C

// Bus widths.
`define IWDG_ADR_W 32
`define IWDG_DAT_W 16

// Register widths.
`define IWDG_KEY_W 16
`define IWDG_PR_W  3
`define IWDG_RLR_W 12

// Key values.
`define IWDG_KEY_ACCESS 16'h5555
`define IWDG_KEY_RELOAD 16'hAAAA
`define IWDG_KEY_START  16'hCCCC

// Reset value of reload register and counter.
`define IWDG_RLR_RST 12'hFFF

// Highest prescaler code with its own divider.
`define IWDG_PR_MAX 6

`endif
